// ==== lsu_top.f ====
common/lsu_pkg.sv
lsu/lsu_align.sv
lsu/lsu_core.sv
hw/clint.sv
hw/sram_slave.sv
hw/lsu_top.sv
tb/lsu_tb.sv

// ==== Makefile ====
# Verilator flow for the load/store unit
# override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= lsu_tb
RTL_TOP   ?= lsu_top
FLIST     ?= lsu_top.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/lsu_tb.sv ====
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int N_WORD       = 64;
    localparam int N_SUB        = 16;
    localparam int N_CLINT      = 8;
    localparam int N_OOR        = 8;
    localparam int N_ACCESS     = 2*N_WORD + 26*N_SUB + 4*N_CLINT + 3*N_OOR + 6;
    localparam int MEM_BYTES    = int'(lsu_pkg::MEM_WORDS) * 4;

    logic           clk;
    logic           reset;
    logic           start;
    logic           wen;
    logic           ren;
    logic           sign;
    lsu_pkg::size_e size;
    logic [31:0]    addr;
    logic [31:0]    wdata;
    logic [31:0]    rdata;
    logic           valid;
    logic           err;
    logic           busy;

    logic [7:0]  shadow [MEM_BYTES]; // byte image of the sram
    logic [31:0] word_addr [N_WORD];
    logic [31:0] rng_state = 32'h47de7bc0;
    logic [32:0] exp_q [$];          // {err, rdata} per access in flight
    logic        chk_q [$];
    logic [32:0] cmp_exp;
    logic        cmp_chk;
    logic [31:0] last_rdata;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          start_cyc = 0;

    lsu_top dut_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .wen   (wen),
        .ren   (ren),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .valid (valid),
        .err   (err),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int size_bytes(input lsu_pkg::size_e sz);
        case (sz)
            lsu_pkg::SZ_BYTE: return 1;
            lsu_pkg::SZ_HALF: return 2;
            lsu_pkg::SZ_WORD: return 4;
            default:          return 0;
        endcase
    endfunction

    // expected {err, rdata} of one access
    function automatic logic [32:0] ref_access(input logic wr, input logic rd,
            input lsu_pkg::size_e sz, input logic sgn, input logic [31:0] a);
        logic [31:0] val;
        int          nb;
        nb  = size_bytes(sz);
        val = 32'h0;
        if (!(wr || rd) || nb == 0)
            return {1'b0, 32'h0};
        if (a >= lsu_pkg::CLINT_BASE && a <= lsu_pkg::CLINT_END)
            return {wr, 32'h0}; // mtime checked by the stimulus
        if (a >= 32'(MEM_BYTES))
            return {1'b1, 32'h0};
        if (wr)
            return {1'b0, 32'h0};
        for (int k = 0; k < nb; k++)
            val[8*k +: 8] = shadow[int'(a) + k];
        if (sgn && nb < 4 && val[8*nb-1])
            val = val | (32'hFFFF_FFFF << (8*nb));
        return {1'b0, val};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
            input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic run_access(input logic wr, input logic rd, input lsu_pkg::size_e sz,
            input logic sgn, input logic [31:0] a, input logic [31:0] d, input logic chk_rd);
        logic [32:0] e;
        int          nb;
        e  = ref_access(wr, rd, sz, sgn, a);
        nb = size_bytes(sz);
        exp_q.push_back(e);
        chk_q.push_back(chk_rd);
        if (wr && nb != 0 && !e[32]) begin
            for (int k = 0; k < nb; k++)
                shadow[int'(a) + k] = d[8*k +: 8];
        end
        wen       = wr;
        ren       = rd;
        size      = sz;
        sign      = sgn;
        addr      = a;
        wdata     = d;
        start     = 1'b1;
        start_cyc = cycles;
        @(negedge clk);
        start = 1'b0;
        while (!valid) begin
            check_value("busy", 32'h1, 32'(busy)); // access still in flight
            @(negedge clk);
        end
        check_value("busy", 32'h0, 32'(busy));
        last_rdata = rdata;
    endtask

    // every valid pulse must match an access in flight
    always @(negedge clk) begin
        if (!reset && valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("valid rose at cycle %0d with no access started", cycles);
            end else begin
                cmp_exp = exp_q.pop_front();
                cmp_chk = chk_q.pop_front();
                check_value("err", 32'(cmp_exp[32]), 32'(err));
                if (cmp_chk)
                    check_value("rdata", cmp_exp[31:0], rdata);
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + N_ACCESS * 40) @(posedge clk);
        $display("timeout: an access got stuck, %0d still waiting for valid", exp_q.size());
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] bad;
        logic [31:0] hi_a;
        logic [31:0] hi_b;
        logic [31:0] lo_a;
        logic [31:0] lo_b;
        logic [31:0] prev_hi;
        int          cyc_a;
        int          cyc_b;
        reset = 1'b1;
        start = 1'b0;
        wen   = 1'b0;
        ren   = 1'b0;
        sign  = 1'b0;
        size  = lsu_pkg::SZ_NONE;
        addr  = 32'h0;
        wdata = 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("busy", 32'h0, 32'(busy));
        check_value("valid", 32'h0, 32'(valid));

        for (int i = 0; i < N_WORD; i++) begin
            r = next_random();
            a = {20'h0, r[11:2], 2'b00};
            word_addr[i] = a;
            run_access(1'b1, 1'b0, lsu_pkg::SZ_WORD, 1'b0, a, next_random(), 1'b0);
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0, 1'b1);
        end

        // sub-word stores, each followed by a full word readback
        for (int i = 0; i < N_SUB; i++) begin
            r = next_random();
            a = {20'h0, r[11:2], 2'b00};
            run_access(1'b1, 1'b0, lsu_pkg::SZ_WORD, 1'b0, a, next_random(), 1'b0);
            for (int off = 0; off < 4; off++) begin
                run_access(1'b1, 1'b0, lsu_pkg::SZ_BYTE, 1'b0, a + 32'(off), next_random(), 1'b0);
                run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0, 1'b1);
            end
            for (int off = 0; off < 4; off += 2) begin
                run_access(1'b1, 1'b0, lsu_pkg::SZ_HALF, 1'b0, a + 32'(off), next_random(), 1'b0);
                run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0, 1'b1);
            end
            for (int s = 0; s < 2; s++) begin
                for (int off = 0; off < 4; off++)
                    run_access(1'b0, 1'b1, lsu_pkg::SZ_BYTE, 1'(s), a + 32'(off), 32'h0, 1'b1);
                for (int off = 0; off < 4; off += 2)
                    run_access(1'b0, 1'b1, lsu_pkg::SZ_HALF, 1'(s), a + 32'(off), 32'h0, 1'b1);
            end
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0, 1'b1);
        end

        prev_hi = 32'h0;
        for (int i = 0; i < N_CLINT; i++) begin
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, lsu_pkg::CLINT_BASE + 32'd4, 32'h0, 1'b0);
            hi_a = last_rdata;
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, lsu_pkg::CLINT_BASE, 32'h0, 1'b0);
            lo_a  = last_rdata;
            cyc_a = start_cyc;
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, lsu_pkg::CLINT_BASE, 32'h0, 1'b0);
            lo_b  = last_rdata;
            cyc_b = start_cyc;
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, lsu_pkg::CLINT_BASE + 32'd4, 32'h0, 1'b0);
            hi_b   = last_rdata;
            checks = checks + 2;
            if (hi_a < prev_hi || hi_b < hi_a) begin
                errors++;
                $display("mtime high word went backwards: %h %h %h", prev_hi, hi_a, hi_b);
            end
            // mtime starts at zero and this run stays below 2**32 cycles
            check_value("mtime_hi", 32'h0, hi_b);
            if (hi_a == hi_b && (lo_b <= lo_a || lo_b - lo_a > 32'(cyc_b - cyc_a))) begin
                errors++;
                $display("mtime low word stepped from %h to %h over %0d cycles",
                         lo_a, lo_b, cyc_b - cyc_a);
            end
            prev_hi = hi_b;
            repeat (int'(next_random() % 8)) @(negedge clk); // idle gap
        end

        // high address bits set, then the aliased word must be untouched
        for (int i = 0; i < N_OOR; i++) begin
            r   = next_random();
            a   = word_addr[int'(r % N_WORD)];
            bad = a | (32'h1000 << (next_random() % 12));
            run_access(1'b1, 1'b0, lsu_pkg::SZ_WORD, 1'b0, bad, next_random(), 1'b0);
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, bad, 32'h0, 1'b1);
            run_access(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0, 1'b1);
        end
        run_access(1'b1, 1'b0, lsu_pkg::SZ_WORD, 1'b0, lsu_pkg::CLINT_BASE, next_random(), 1'b0);
        run_access(1'b1, 1'b0, lsu_pkg::SZ_BYTE, 1'b0, lsu_pkg::CLINT_BASE + 32'd4,
                   next_random(), 1'b0);

        // accesses that never reach a bus
        run_access(1'b0, 1'b0, lsu_pkg::SZ_WORD, 1'b0, word_addr[0], 32'h0, 1'b0);
        run_access(1'b1, 1'b0, lsu_pkg::SZ_NONE, 1'b0, word_addr[1], next_random(), 1'b0);
        run_access(1'b0, 1'b1, lsu_pkg::SZ_NONE, 1'b0, word_addr[2], 32'h0, 1'b0);
        run_access(1'b1, 1'b1, lsu_pkg::SZ_NONE, 1'b1, word_addr[3], next_random(), 1'b0);

        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d accesses ended without valid", exp_q.size());
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`default_nettype none

module lsu_top (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           start,
    input  wire logic           wen,
    input  wire logic           ren,
    input  wire logic           sign,
    input  wire lsu_pkg::size_e size,
    input  wire logic [31:0]    addr,
    input  wire logic [31:0]    wdata,
    output logic [31:0]         rdata,
    output logic                valid,
    output logic                err,
    output logic                busy
);

    // sram channels
    logic        mem_arvalid;
    logic        mem_arready;
    logic [31:0] mem_araddr;
    logic [2:0]  mem_arsize;
    logic        mem_rvalid;
    logic        mem_rready;
    logic [31:0] mem_rdata;
    logic [1:0]  mem_rresp;
    logic        mem_awvalid;
    logic        mem_awready;
    logic [31:0] mem_awaddr;
    logic [2:0]  mem_awsize;
    logic        mem_wvalid;
    logic        mem_wready;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_bvalid;
    logic        mem_bready;
    logic [1:0]  mem_bresp;

    // clint read channels
    logic        clint_arvalid;
    logic        clint_arready;
    logic [31:0] clint_araddr;
    logic        clint_rvalid;
    logic        clint_rready;
    logic [31:0] clint_rdata;
    logic [1:0]  clint_rresp;

    lsu_core u_core (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .wen           (wen),
        .ren           (ren),
        .sign          (sign),
        .size          (size),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .valid         (valid),
        .err           (err),
        .busy          (busy),
        .mem_arvalid   (mem_arvalid),
        .mem_arready   (mem_arready),
        .mem_araddr    (mem_araddr),
        .mem_arsize    (mem_arsize),
        .mem_rvalid    (mem_rvalid),
        .mem_rready    (mem_rready),
        .mem_rdata     (mem_rdata),
        .mem_rresp     (mem_rresp),
        .mem_awvalid   (mem_awvalid),
        .mem_awready   (mem_awready),
        .mem_awaddr    (mem_awaddr),
        .mem_awsize    (mem_awsize),
        .mem_wvalid    (mem_wvalid),
        .mem_wready    (mem_wready),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_bvalid    (mem_bvalid),
        .mem_bready    (mem_bready),
        .mem_bresp     (mem_bresp),
        .clint_arvalid (clint_arvalid),
        .clint_arready (clint_arready),
        .clint_araddr  (clint_araddr),
        .clint_rvalid  (clint_rvalid),
        .clint_rready  (clint_rready),
        .clint_rdata   (clint_rdata),
        .clint_rresp   (clint_rresp)
    );

    clint u_clint (
        .clk     (clk),
        .reset   (reset),
        .arvalid (clint_arvalid),
        .araddr  (clint_araddr),
        .arready (clint_arready),
        .rvalid  (clint_rvalid),
        .rdata   (clint_rdata),
        .rresp   (clint_rresp),
        .rready  (clint_rready)
    );

    sram_slave u_sram (
        .clk     (clk),
        .reset   (reset),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .araddr  (mem_araddr),
        .arsize  (mem_arsize),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready),
        .rdata   (mem_rdata),
        .rresp   (mem_rresp),
        .awvalid (mem_awvalid),
        .awready (mem_awready),
        .awaddr  (mem_awaddr),
        .awsize  (mem_awsize),
        .wvalid  (mem_wvalid),
        .wready  (mem_wready),
        .wdata   (mem_wdata),
        .wstrb   (mem_wstrb),
        .bvalid  (mem_bvalid),
        .bready  (mem_bready),
        .bresp   (mem_bresp)
    );

endmodule

`default_nettype wire

// ==== hw/sram_slave.sv ====
`default_nettype none

module sram_slave (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           arvalid,
    output logic                arready,
    input  wire logic [31:0]    araddr,
    input  wire logic [2:0]     arsize,
    output logic                rvalid,
    input  wire logic           rready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    input  wire logic           awvalid,
    output logic                awready,
    input  wire logic [31:0]    awaddr,
    input  wire logic [2:0]     awsize,
    input  wire logic           wvalid,
    output logic                wready,
    input  wire logic [31:0]    wdata,
    input  wire logic [3:0]     wstrb,
    output logic                bvalid,
    input  wire logic           bready,
    output logic [1:0]          bresp
);

    logic [31:0] mem [lsu_pkg::MEM_WORDS];

    logic [$clog2(lsu_pkg::MEM_WORDS)-1:0] ar_idx;
    logic [$clog2(lsu_pkg::MEM_WORDS)-1:0] aw_idx; // held from aw to w
    logic                                  aw_ok;
    logic                                  ar_hit;
    logic                                  aw_hit;
    logic                                  idle;

    assign idle    = !(rvalid || wready || bvalid);
    assign arready = idle;
    assign awready = idle;
    assign ar_idx  = araddr[$clog2(lsu_pkg::MEM_WORDS)+1:2];

    // in range and no wider than the 32-bit bus
    assign ar_hit = ((araddr >> 2) < 32'(lsu_pkg::MEM_WORDS)) && (arsize <= 3'd2);
    assign aw_hit = ((awaddr >> 2) < 32'(lsu_pkg::MEM_WORDS)) && (awsize <= 3'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (arvalid && arready)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;

            if (awvalid && awready)
                wready <= 1'b1;
            else if (wvalid && wready)
                wready <= 1'b0;

            if (wvalid && wready)
                bvalid <= 1'b1;
            else if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= ar_hit ? mem[ar_idx] : 32'h0;
            rresp <= ar_hit ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
        end
        if (awvalid && awready) begin
            aw_idx <= awaddr[$clog2(lsu_pkg::MEM_WORDS)+1:2];
            aw_ok  <= aw_hit;
        end
        if (wvalid && wready) begin
            for (int i = 0; i < 4; i++) begin
                if (aw_ok && wstrb[i])
                    mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8]; // strobed bytes only
            end
            bresp <= aw_ok ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== hw/clint.sv ====
`default_nettype none

module clint (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           arvalid,
    input  wire logic [31:0]    araddr,
    output logic                arready,
    output logic                rvalid,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    input  wire logic           rready
);

    logic [63:0] mtime;
    logic        in_win;

    assign arready = 1'b1;
    assign in_win  = (araddr >= lsu_pkg::CLINT_BASE) && (araddr <= lsu_pkg::CLINT_END);

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime  <= 64'h0;
            rvalid <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1; // free running
            if (arvalid && arready)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    // word select sampled at the ar transfer
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];
            rresp <= in_win ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== lsu/lsu_core.sv ====
`default_nettype none

module lsu_core (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           start,
    input  wire logic           wen,
    input  wire logic           ren,
    input  wire logic           sign,
    input  wire lsu_pkg::size_e size,
    input  wire logic [31:0]    addr,
    input  wire logic [31:0]    wdata,
    output logic [31:0]         rdata,
    output logic                valid,
    output logic                err,
    output logic                busy,
    // sram master
    output logic                mem_arvalid,
    input  wire logic           mem_arready,
    output logic [31:0]         mem_araddr,
    output logic [2:0]          mem_arsize,
    input  wire logic           mem_rvalid,
    output logic                mem_rready,
    input  wire logic [31:0]    mem_rdata,
    input  wire logic [1:0]     mem_rresp,
    output logic                mem_awvalid,
    input  wire logic           mem_awready,
    output logic [31:0]         mem_awaddr,
    output logic [2:0]          mem_awsize,
    output logic                mem_wvalid,
    input  wire logic           mem_wready,
    output logic [31:0]         mem_wdata,
    output logic [3:0]          mem_wstrb,
    input  wire logic           mem_bvalid,
    output logic                mem_bready,
    input  wire logic [1:0]     mem_bresp,
    // clint master, read only
    output logic                clint_arvalid,
    input  wire logic           clint_arready,
    output logic [31:0]         clint_araddr,
    input  wire logic           clint_rvalid,
    output logic                clint_rready,
    input  wire logic [31:0]    clint_rdata,
    input  wire logic [1:0]     clint_rresp
);

    lsu_pkg::lsu_state_e state;
    lsu_pkg::size_e      size_q;
    logic [31:0]         addr_q;
    logic [31:0]         wdata_q;
    logic [31:0]         raw_q;
    logic                sign_q;
    logic                clint_q;

    logic                hit_clint;
    logic                nop;
    logic                ar_ready;
    logic                r_valid;
    logic [31:0]         r_data;
    logic [1:0]          r_resp;
    logic [2:0]          axsize;
    logic [31:0]         bus_wdata;
    logic [3:0]          wstrb;

    assign hit_clint = (addr >= lsu_pkg::CLINT_BASE) && (addr <= lsu_pkg::CLINT_END);
    assign nop       = !(wen || ren) || (size == lsu_pkg::SZ_NONE);
    assign busy      = (state != lsu_pkg::ST_IDLE);

    // read channel steering
    assign ar_ready = clint_q ? clint_arready : mem_arready;
    assign r_valid  = clint_q ? clint_rvalid  : mem_rvalid;
    assign r_data   = clint_q ? clint_rdata   : mem_rdata;
    assign r_resp   = clint_q ? clint_rresp   : mem_rresp;

    assign mem_arvalid   = (state == lsu_pkg::ST_AR) && !clint_q;
    assign clint_arvalid = (state == lsu_pkg::ST_AR) && clint_q;
    assign mem_araddr    = addr_q;
    assign clint_araddr  = addr_q;
    assign mem_arsize    = axsize;
    assign mem_rready    = 1'b1;
    assign clint_rready  = 1'b1;

    // writes only ever go to sram
    assign mem_awvalid = (state == lsu_pkg::ST_AW);
    assign mem_awaddr  = addr_q;
    assign mem_awsize  = axsize;
    assign mem_wvalid  = (state == lsu_pkg::ST_W);
    assign mem_wdata   = bus_wdata;
    assign mem_wstrb   = wstrb;
    assign mem_bready  = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lsu_pkg::ST_IDLE;
            valid <= 1'b0;
            err   <= 1'b0;
        end else begin
            valid <= 1'b0; // one-cycle pulse
            case (state)
                lsu_pkg::ST_IDLE: begin
                    if (start) begin
                        if (nop) begin
                            valid <= 1'b1;
                            err   <= 1'b0;
                        end else if (wen && hit_clint) begin
                            valid <= 1'b1; // clint is read only
                            err   <= 1'b1;
                        end else if (wen) begin
                            state <= lsu_pkg::ST_AW;
                        end else begin
                            state <= lsu_pkg::ST_AR;
                        end
                    end
                end
                lsu_pkg::ST_AR: if (ar_ready) state <= lsu_pkg::ST_R;
                lsu_pkg::ST_R: begin
                    if (r_valid) begin
                        state <= lsu_pkg::ST_IDLE;
                        valid <= 1'b1;
                        err   <= (r_resp != lsu_pkg::RESP_OKAY);
                    end
                end
                lsu_pkg::ST_AW: if (mem_awready) state <= lsu_pkg::ST_W;
                lsu_pkg::ST_W:  if (mem_wready) state <= lsu_pkg::ST_B;
                lsu_pkg::ST_B: begin
                    if (mem_bvalid) begin
                        state <= lsu_pkg::ST_IDLE;
                        valid <= 1'b1;
                        err   <= (mem_bresp != lsu_pkg::RESP_OKAY);
                    end
                end
                default: state <= lsu_pkg::ST_IDLE;
            endcase
        end
    end

    // request latch and raw read word
    always_ff @(posedge clk) begin
        if (state == lsu_pkg::ST_IDLE && start) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            size_q  <= size;
            sign_q  <= sign;
            clint_q <= hit_clint;
            raw_q   <= 32'h0;
        end else if (state == lsu_pkg::ST_R && r_valid) begin
            raw_q <= r_data;
        end
    end

    lsu_align u_align (
        .addr_low  (addr_q[1:0]),
        .size      (size_q),
        .sign      (sign_q),
        .wdata     (wdata_q),
        .raw_rdata (raw_q),
        .wstrb     (wstrb),
        .bus_wdata (bus_wdata),
        .axsize    (axsize),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

// ==== lsu/lsu_align.sv ====
`default_nettype none

module lsu_align (
    input  wire logic [1:0]     addr_low,
    input  wire lsu_pkg::size_e size,
    input  wire logic           sign,
    input  wire logic [31:0]    wdata,
    input  wire logic [31:0]    raw_rdata,
    output logic [3:0]          wstrb,
    output logic [31:0]         bus_wdata,
    output logic [2:0]          axsize,
    output logic [31:0]         rdata
);

    logic [31:0] shifted;

    assign bus_wdata = wdata << {addr_low, 3'b000};  // move store data into its lane
    assign shifted   = raw_rdata >> {addr_low, 3'b000};

    always_comb begin
        case (size)
            lsu_pkg::SZ_BYTE: begin
                wstrb  = 4'b0001 << addr_low;
                axsize = 3'd0;
                rdata  = {{24{sign & shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::SZ_HALF: begin
                wstrb  = addr_low[1] ? 4'b1100 : 4'b0011; // aligned half only
                axsize = 3'd1;
                rdata  = {{16{sign & shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::SZ_WORD: begin
                wstrb  = 4'b1111;
                axsize = 3'd2;
                rdata  = shifted;
            end
            default: begin
                // no access width, nothing on the bus
                wstrb  = 4'b0000;
                axsize = 3'd0;
                rdata  = 32'h0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== common/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // mtime window, low word at base, high word at base+4
    localparam logic [31:0] CLINT_BASE = 32'h0200_0048;
    localparam logic [31:0] CLINT_END  = 32'h0200_004F;

    localparam int unsigned MEM_WORDS = 1024; // sram depth in 32-bit words

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        SZ_NONE,
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } size_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AR,
        ST_R,
        ST_AW,
        ST_W,
        ST_B
    } lsu_state_e;

endpackage

`default_nettype wire
